// ==== common/i3c_target_pkg.sv ====
// I3C target bus definitions
package i3c_target_pkg;

  // One SDR data byte as it leaves the bus deserializer.
  localparam int unsigned RxByteWidth = 8;

  // Width of the error code carried in an RX descriptor.
  localparam int unsigned RxErrWidth = 4;

  // Receive error codes reported to software in the RX descriptor.
  // Only overflow is produced by this path, the rest of the code space
  // stays free for future bus-level errors such as parity.
  typedef enum logic [RxErrWidth-1:0] {
    RxErrNone     = 4'd0, // Transfer completed, every byte was queued.
    RxErrOverflow = 4'd1  // The data queue filled up and later bytes were lost.
  } rx_err_e;

endpackage

// ==== common/tti_pkg.sv ====
// TTI queue definitions
package tti_pkg;

  // Byte counter width, which also bounds the length of one transfer.
  localparam int unsigned RxByteCountWidth = 16;

  // Bits between the error code and the byte count.
  localparam int unsigned RxDescReservedWidth = 12;

  // Default queue depths, in entries.
  localparam int unsigned DefaultRxDataDepth = 16; // Bytes.
  localparam int unsigned DefaultRxDescDepth = 4;  // Descriptors.

  // RX descriptor as software reads it.
  // The error code sits in the top nibble, the byte count in the low half.
  typedef struct packed {
    i3c_target_pkg::rx_err_e err;              // Bits 31 to 28.
    logic [RxDescReservedWidth-1:0] reserved;  // Bits 27 to 16, always zero.
    logic [RxByteCountWidth-1:0] byte_count;   // Bits 15 to 0, accepted bytes.
  } rx_desc_t;

endpackage

// ==== common/rx_byte_if.sv ====
// Receive byte stream interface
interface rx_byte_if;

  logic [i3c_target_pkg::RxByteWidth-1:0] data_byte; // Byte from the bus.
  logic valid; // One cycle per byte, only while ready is high.
  logic last;  // Ends the transfer, alone or together with its final byte.
  logic err;   // Ends the transfer on overflow, never together with valid.
  logic ready; // Data queue has room for one more byte.

  // The receive stage drives the stream.
  modport source (
    output data_byte, valid, last, err,
    input  ready
  );

  // The descriptor stage consumes it and reports space back.
  modport sink (
    input  data_byte, valid, last, err,
    output ready
  );

endinterface

// ==== tti_queue/tti_fifo.sv ====
// TTI queue with commit on flush
module tti_fifo #(
  parameter type         payload_t = logic [7:0], // Entry type.
  parameter int unsigned Depth     = 16           // Number of entries.
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wvalid_i, // Push wdata_i, ignored while full.
  input  payload_t wdata_i,
  input  logic     wflush_i, // Commit all earlier pushes.
  output logic     full_o,   // Every slot holds an unread entry.
  output logic     rvalid_o, // A committed entry is waiting.
  output payload_t rdata_o,
  input  logic     rready_i
);

  // Index width plus one wrap bit, so full and empty can be told apart.
  localparam int unsigned AddrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned PtrW  = AddrW + 1;

  payload_t mem [Depth]; // Entry storage.

  logic [PtrW-1:0] wr_ptr_q;  // Next slot to write.
  logic [PtrW-1:0] rd_ptr_q;  // Next slot to read.
  logic [PtrW-1:0] cmt_ptr_q; // Reads may not pass this slot.
  logic            push;
  logic            pop;

  // Advances a pointer and wraps at Depth, which need not be a power of two.
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] nxt;
    if (ptr[AddrW-1:0] == AddrW'(Depth - 1)) begin
      nxt = {~ptr[PtrW-1], {AddrW{1'b0}}}; // Back to slot 0, flip the wrap bit.
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // Full looks at the write pointer, so uncommitted entries take space too.
  assign full_o   = (wr_ptr_q[AddrW-1:0] == rd_ptr_q[AddrW-1:0]) &&
                    (wr_ptr_q[PtrW-1] != rd_ptr_q[PtrW-1]);
  assign rvalid_o = (cmt_ptr_q != rd_ptr_q);
  assign rdata_o  = mem[rd_ptr_q[AddrW-1:0]];

  assign push = wvalid_i & ~full_o; // A write into a full queue is lost.
  assign pop  = rvalid_o & rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      cmt_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // The commit takes the write pointer as it stands before this cycle's push.
      // Readers see the entries from the cycle after the flush edge.
      if (wflush_i) begin
        cmt_ptr_q <= wr_ptr_q;
      end
    end
  end

  // Write port of the entry storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q[AddrW-1:0]] <= wdata_i;
    end
  end

endmodule

// ==== design/private_write_rx.sv ====
// Private Write receive stage
module private_write_rx (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [i3c_target_pkg::RxByteWidth-1:0] bus_byte_i,       // Byte off the bus.
  input  logic                                   bus_byte_valid_i, // One cycle per byte.
  input  logic                                   bus_byte_last_i,  // Final byte of transfer.
  rx_byte_if.source                              rx_o
);

  logic [i3c_target_pkg::RxByteWidth-1:0] byte_q; // Byte waiting for the queue.
  logic valid_q;   // A byte is due on the stream this cycle.
  logic last_q;    // The transfer ends this cycle.
  logic discard_q; // Drops every byte until bus last after an overflow.
  logic overflow;  // The byte due now finds the queue full.
  logic drop;      // Bus byte sampled at the coming edge is thrown away.

  // Ready is checked in the cycle a byte is due, not when it was sampled.
  // That way the write of the previous byte is already reflected in full.
  assign overflow = valid_q & ~rx_o.ready;

  // An overflow on a byte that is not the last starts the discard right away,
  // so the next bus byte sampled at the end of this cycle is already dropped.
  assign drop = discard_q | (overflow & ~last_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      last_q    <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      valid_q <= bus_byte_valid_i & ~drop;
      last_q  <= bus_byte_last_i & ~drop; // A bare last is passed on as well.
      if (bus_byte_last_i) begin
        discard_q <= 1'b0; // Bus transfer is over, the next one starts clean.
      end else if (overflow && !last_q) begin
        discard_q <= 1'b1; // More bytes follow that the queue cannot take.
      end
    end
  end

  // The payload register loads whenever the bus presents a byte.
  always_ff @(posedge clk_i) begin
    if (bus_byte_valid_i) begin
      byte_q <= bus_byte_i;
    end
  end

  assign rx_o.data_byte = byte_q;
  assign rx_o.valid     = valid_q & rx_o.ready; // Forwarded only when there is room.

  // A refused byte turns into the error strobe.
  // It also ends the transfer, so last is held back in that cycle.
  assign rx_o.err  = overflow;
  assign rx_o.last = last_q & ~overflow;

endmodule

// ==== design/descriptor_rx.sv ====
// RX descriptor generator
module descriptor_rx #(
  parameter int unsigned RxDescDataWidth = 32 // Width of one descriptor word.
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  rx_byte_if.sink                                rx_i,
  input  logic                                   data_full_i,   // Data queue has no room.
  output logic                                   data_wvalid_o, // Push one byte.
  output logic [i3c_target_pkg::RxByteWidth-1:0] data_wdata_o,
  output logic                                   data_wflush_o, // Commit the transfer.
  output logic                                   desc_wvalid_o, // Push one descriptor.
  output tti_pkg::rx_desc_t                      desc_wdata_o
);

  localparam int unsigned CntW = tti_pkg::RxByteCountWidth;
  localparam int unsigned PadW = RxDescDataWidth - i3c_target_pkg::RxErrWidth - CntW;

  logic [CntW-1:0] count_q;    // Bytes accepted so far in this transfer.
  logic [CntW-1:0] byte_count; // Count including the byte accepted this cycle.
  logic            accept;     // A byte goes into the data queue now.
  logic            ended;      // Transfer ends this cycle, by last or by error.
  logic            ended_q;    // Transfer ended in the previous cycle.
  i3c_target_pkg::rx_err_e err_code;
  logic [RxDescDataWidth-1:0] desc_flat;

  assign rx_i.ready = ~data_full_i;
  assign accept     = rx_i.valid & rx_i.ready;
  assign ended      = rx_i.last | rx_i.err;
  assign byte_count = count_q + CntW'(accept); // The final byte may come with last.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      ended_q <= 1'b0;
    end else begin
      ended_q <= ended;
      if (ended) begin
        count_q <= '0; // Error clears the count just like last.
      end else if (accept) begin
        count_q <= byte_count;
      end
    end
  end

  // Bytes go straight through in the cycle they are valid.
  assign data_wvalid_o = accept;
  assign data_wdata_o  = rx_i.data_byte;

  assign err_code  = rx_i.err ? i3c_target_pkg::RxErrOverflow : i3c_target_pkg::RxErrNone;
  assign desc_flat = {err_code, {PadW{1'b0}}, byte_count};

  // The descriptor is pushed in the cycle the transfer ends but stays hidden.
  // One cycle later the shared flush commits it together with the data bytes,
  // and a byte of a following transfer written in that cycle is not included.
  assign desc_wvalid_o = ended;
  assign desc_wdata_o  = tti_pkg::rx_desc_t'(desc_flat);
  assign data_wflush_o = ended_q;

endmodule

// ==== design/rx_tti_top.sv ====
// TTI receive path top level
module rx_tti_top #(
  parameter int unsigned RxDataDepth = tti_pkg::DefaultRxDataDepth, // Data queue bytes.
  parameter int unsigned RxDescDepth = tti_pkg::DefaultRxDescDepth  // Descriptor entries.
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic [i3c_target_pkg::RxByteWidth-1:0]      bus_byte_i,
  input  logic                                        bus_byte_valid_i,
  input  logic                                        bus_byte_last_i,
  output logic                                        rx_data_rvalid_o,
  output logic [i3c_target_pkg::RxByteWidth-1:0]      rx_data_rdata_o,
  input  logic                                        rx_data_rready_i,
  output logic                                        rx_desc_rvalid_o,
  output logic [$bits(tti_pkg::rx_desc_t)-1:0]        rx_desc_rdata_o,
  input  logic                                        rx_desc_rready_i
);

  logic                                   data_full;   // Data queue cannot take a byte.
  logic                                   data_wvalid;
  logic [i3c_target_pkg::RxByteWidth-1:0] data_wdata;
  logic                                   data_wflush; // Commits data and descriptor.
  logic                                   desc_wvalid;
  tti_pkg::rx_desc_t                      desc_wdata;
  tti_pkg::rx_desc_t                      desc_rdata;

  rx_byte_if rx_bus ();

  // Registers bus bytes and handles overflow.
  private_write_rx pw_rx (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus_byte_i       (bus_byte_i),
    .bus_byte_valid_i (bus_byte_valid_i),
    .bus_byte_last_i  (bus_byte_last_i),
    .rx_o             (rx_bus.source)
  );

  descriptor_rx #(
    .RxDescDataWidth ($bits(tti_pkg::rx_desc_t))
  ) desc_rx (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rx_i          (rx_bus.sink),
    .data_full_i   (data_full),
    .data_wvalid_o (data_wvalid),
    .data_wdata_o  (data_wdata),
    .data_wflush_o (data_wflush),
    .desc_wvalid_o (desc_wvalid),
    .desc_wdata_o  (desc_wdata)
  );

  tti_fifo #(
    .payload_t (logic [i3c_target_pkg::RxByteWidth-1:0]),
    .Depth     (RxDataDepth)
  ) data_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (data_wvalid),
    .wdata_i  (data_wdata),
    .wflush_i (data_wflush),
    .full_o   (data_full),
    .rvalid_o (rx_data_rvalid_o),
    .rdata_o  (rx_data_rdata_o),
    .rready_i (rx_data_rready_i)
  );

  // Same flush as the data queue, so a descriptor and its bytes appear together.
  // A write while this queue is full is dropped and nothing reports it.
  tti_fifo #(
    .payload_t (tti_pkg::rx_desc_t),
    .Depth     (RxDescDepth)
  ) desc_queue (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (desc_wvalid),
    .wdata_i  (desc_wdata),
    .wflush_i (data_wflush),
    .full_o   (),
    .rvalid_o (rx_desc_rvalid_o),
    .rdata_o  (desc_rdata),
    .rready_i (rx_desc_rready_i)
  );

  assign rx_desc_rdata_o = desc_rdata; // Flat 32-bit word for software.

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset
module tb_clock_gen #(
  parameter int unsigned Period      = 20, // Clock period in time units.
  parameter int unsigned ResetCycles = 5   // Rising edges seen while reset is low.
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Reset is released on a falling edge, well away from the sampling edge.
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tests/tb_rx_tti.sv ====
// TTI receive path testbench
module tb_rx_tti;

  localparam int RxDataDepth = 16;
  localparam int RxDescDepth = 4;

  logic       clk;
  logic       rst_n;
  logic [7:0] bus_byte;
  logic       bus_valid;
  logic       bus_last;
  logic       data_rvalid;
  logic [7:0] data_rdata;
  logic       data_rready;
  logic       desc_rvalid;
  logic [31:0] desc_rdata;
  logic       desc_rready;

  logic        idle_since_reset; // No bus byte has been driven yet.
  logic        quiet_chk;        // Nothing may be readable while this transfer is in flight.
  logic        lat_chk_en;       // The last byte now driven starts the latency check.
  logic [7:0]  exp_data [$];     // Bytes the reader must see, in order.
  int          exp_tag [$];      // Transfer index of each expected byte.
  logic [31:0] exp_desc [$];     // Descriptors the reader must see, in order.
  int          xfer_count;       // Transfers sent so far.
  int          desc_reads;       // Descriptors popped so far.
  int          watchdog_cycles;
  int          len_free [8];     // Lengths for the free-draining transfers.
  int          len_lat [3];      // Lengths for the latency transfers.
  int          len_b2b [6];      // Lengths for the back-to-back transfers.
  int          total_bytes;
  int          k;

  tb_clock_gen #(.Period(20), .ResetCycles(5)) clk_gen (.clk_o(clk), .rst_no(rst_n));

  rx_tti_top #(
    .RxDataDepth (RxDataDepth),
    .RxDescDepth (RxDescDepth)
  ) dut0 (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .bus_byte_i       (bus_byte),
    .bus_byte_valid_i (bus_valid),
    .bus_byte_last_i  (bus_last),
    .rx_data_rvalid_o (data_rvalid),
    .rx_data_rdata_o  (data_rdata),
    .rx_data_rready_i (data_rready),
    .rx_desc_rvalid_o (desc_rvalid),
    .rx_desc_rdata_o  (desc_rdata),
    .rx_desc_rready_i (desc_rready)
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "Run stopped at the first failure.");
  endtask

  task automatic report_mismatch(input string what);
    fail_run($sformatf("Error at time %0t: %s", $time, what));
  endtask

  // Drives one transfer byte by byte and predicts what the reader gets.
  task automatic send_transfer(input int len, input bit reader_stalled, input bit check_latency);
    int         free_slots;
    int         accepted;
    int         i;
    bit         overflowed;
    logic [7:0] value;
    // Only a stalled reader can fill the queue. The space is then what is left unread.
    free_slots = reader_stalled ? RxDataDepth - exp_data.size() : len;
    accepted   = 0;
    overflowed = 1'b0;
    for (i = 0; i < len; i++) begin
      @(negedge clk);
      value            = 8'($urandom);
      bus_byte         = value;
      bus_valid        = 1'b1;
      bus_last         = (i == len - 1);
      quiet_chk        = check_latency && (i != len - 1);
      lat_chk_en       = check_latency && (i == len - 1);
      idle_since_reset = 1'b0;
      if (!overflowed && accepted < free_slots) begin
        exp_data.push_back(value);
        exp_tag.push_back(xfer_count);
        accepted++;
      end else begin
        overflowed = 1'b1; // This byte and the rest of the transfer are lost.
      end
    end
    // Error code on top, twelve reserved zero bits, byte count below.
    exp_desc.push_back({(overflowed ? 4'd1 : 4'd0), 12'h000, 16'(accepted)});
    xfer_count++;
  endtask

  task automatic end_bus();
    @(negedge clk);
    bus_valid  = 1'b0;
    bus_last   = 1'b0;
    quiet_chk  = 1'b0;
    lat_chk_en = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_data.size() != 0 || exp_desc.size() != 0) @(negedge clk);
  endtask

  // Pops happen on this edge, so the values read here are the ones being taken.
  always @(posedge clk) begin
    if (rst_n) begin
      if (desc_rvalid && desc_rready) begin
        desc_expected: assert (exp_desc.size() != 0)
          else fail_run("A descriptor was read although no transfer had ended.");
        desc_value: assert (desc_rdata == exp_desc[0])
          else report_mismatch($sformatf("descriptor 0x%08h, expected 0x%08h",
                                         desc_rdata, exp_desc[0]));
        void'(exp_desc.pop_front());
        desc_reads++;
      end
      if (data_rvalid && data_rready) begin
        data_expected: assert (exp_data.size() != 0)
          else fail_run("A data byte was read although none was expected.");
        data_value: assert (data_rdata == exp_data[0])
          else report_mismatch($sformatf("data byte 0x%02h, expected 0x%02h",
                                         data_rdata, exp_data[0]));
        data_order: assert (exp_tag[0] < desc_reads) // Bytes never run ahead of their descriptor.
          else report_mismatch($sformatf("byte of transfer %0d read before its descriptor",
                                         exp_tag[0]));
        void'(exp_data.pop_front());
        void'(exp_tag.pop_front());
      end
    end
  end

  no_early_commit: assert property (@(posedge clk) disable iff (!rst_n)
    idle_since_reset |-> !data_rvalid && !desc_rvalid)
    else report_mismatch("rvalid high before any transfer was sent");

  no_partial_read: assert property (@(posedge clk) disable iff (!rst_n)
    quiet_chk |-> !data_rvalid && !desc_rvalid)
    else report_mismatch("data readable in the middle of a transfer");

  // Edge E0 samples the bus last, the commit edge is E2, the reader sees it at E3.
  commit_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(lat_chk_en && bus_last, 3) |->
      data_rvalid && desc_rvalid && !$past(data_rvalid, 1) &&
      !$past(data_rvalid, 2) && !$past(data_rvalid, 3))
    else report_mismatch("commit did not appear exactly 3 edges after the bus last");

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    fail_run("Timeout: the expected data or descriptors never came out of the DUT.");
  end

  initial begin
    bus_byte         = 8'h00;
    bus_valid        = 1'b0;
    bus_last         = 1'b0;
    data_rready      = 1'b1;
    desc_rready      = 1'b1;
    idle_since_reset = 1'b1;
    quiet_chk        = 1'b0;
    lat_chk_en       = 1'b0;
    xfer_count       = 0;
    desc_reads       = 0;
    void'($urandom(58));
    total_bytes = 20; // The overflow transfer.
    for (k = 0; k < 8; k++) begin
      len_free[k] = 1 + int'($urandom % 12);
      total_bytes += len_free[k];
    end
    // At least two bytes, so every latency transfer has a middle to check.
    for (k = 0; k < 3; k++) begin
      len_lat[k] = 2 + int'($urandom % 11);
      total_bytes += len_lat[k];
    end
    for (k = 0; k < 6; k++) begin
      len_b2b[k] = 1 + int'($urandom % 12);
      total_bytes += len_b2b[k];
    end
    watchdog_cycles = total_bytes * 40 + 200;

    @(posedge rst_n);
    @(negedge clk);
    reset_state: assert (!data_rvalid && !desc_rvalid)
      else report_mismatch("rvalid high right after reset");
    repeat (5) @(negedge clk); // Both rvalid outputs must stay low while the bus is idle.

    for (k = 0; k < 8; k++) begin
      send_transfer(len_free[k], 1'b0, 1'b0);
      end_bus();
      repeat ($urandom % 4) @(negedge clk);
    end
    wait_drained();

    // Each latency transfer starts on an empty path.
    for (k = 0; k < 3; k++) begin
      send_transfer(len_lat[k], 1'b0, 1'b1);
      end_bus();
      wait_drained();
      repeat (2) @(negedge clk);
    end

    // Reader stalled, so only 16 of the 20 bytes fit.
    @(negedge clk);
    data_rready = 1'b0;
    send_transfer(20, 1'b1, 1'b0);
    end_bus();
    while (exp_desc.size() != 0) @(negedge clk);
    repeat (3) @(negedge clk);
    stall_holds: assert (data_rvalid)
      else report_mismatch("overflowed bytes not readable after the descriptor");
    data_rready = 1'b1;
    wait_drained();

    for (k = 0; k < 6; k++) begin
      send_transfer(len_b2b[k], 1'b0, 1'b0); // Next first byte follows the last at once.
    end
    end_bus();
    wait_drained();
    repeat (10) @(negedge clk);

    if (exp_data.size() == 0 && exp_desc.size() == 0 && !data_rvalid && !desc_rvalid) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_run("Data or descriptors were left in the queues at the end of the run.");
    end
  end

endmodule

// ==== build.f ====
common/i3c_target_pkg.sv
common/tti_pkg.sv
common/rx_byte_if.sv
tti_queue/tti_fifo.sv
design/private_write_rx.sv
design/descriptor_rx.sv
design/rx_tti_top.sv
tests/tb_clock_gen.sv
tests/tb_rx_tti.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the result line.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_rx_tti &&
  ./obj_dir/Vtb_rx_tti | tee /dev/stderr | grep -q "sim passed" &&
  echo "Result: PASS" ||
  { echo "Result: FAIL"; exit 1; }
